//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ########################################
	// types
	// ########################################

	// byte address into instruction memory. Instructions are halfwords, so bit 0 is zero.
	typedef logic [25:0] fetch_addr_t;

	typedef logic [15:0] instr_word_t;

	// one memory line of eight words, word 0 at the lowest address.
	typedef instr_word_t [7:0] fetch_line_t;

	// level of the downstream instruction queue, 0 to 16.
	typedef logic [4:0] fifo_level_t;

	// number of words a line delivers, 1 to 8.
	typedef logic [3:0] word_count_t;

	// ########################################
	// constants
	// ########################################

	localparam int LINE_WORDS = 8;
	localparam int FIFO_DEPTH = 16;

	localparam fetch_addr_t RESET_FETCH_ADDR = 26'h7FE0;

	// a jump word has all ones in bits 15 to 11 and one of these kinds in bits 10 to 8.
	localparam logic [4:0] JUMP_PREFIX = 5'b11111;
	localparam logic [2:0] JUMP_KIND_A = 3'b010;
	localparam logic [2:0] JUMP_KIND_B = 3'b011;
	localparam logic [2:0] JUMP_KIND_C = 3'b110;

endpackage

`default_nettype wire

//--- verilog/fetch_status_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_status_if;

	import fetch_pkg::*;

	logic is_requesting;
	logic jump_active;
	logic line_ack;

	// words the current line delivers, counted from the fetch address to the line end.
	word_count_t returned_words;

	modport seq (
		output is_requesting,
		output jump_active,
		output line_ack,
		output returned_words
	);

	modport tracker (
		input is_requesting,
		input jump_active,
		input line_ack,
		input returned_words
	);

endinterface

`default_nettype wire

//--- verilog/jump_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module jump_scanner (
	input  fetch_pkg::fetch_line_t line,
	input  fetch_pkg::word_count_t valid_words,
	output logic                   jump_found
);

	import fetch_pkg::*;

	logic [LINE_WORDS-1:0] word_is_jump;
	logic [LINE_WORDS-1:0] word_in_tail;
	word_count_t           first_valid;

	// the fetch address may point into the middle of a line.
	// only the words from there to the end of the line are delivered.
	assign first_valid = word_count_t'(LINE_WORDS) - valid_words;

	for (genvar i = 0; i < LINE_WORDS; i++) begin : g_word
		instr_word_t word;
		logic [2:0]  kind;

		assign word = line[i];
		assign kind = word[10:8];

		assign word_is_jump[i] = (word[15:11] == JUMP_PREFIX) &&
			(kind == JUMP_KIND_A || kind == JUMP_KIND_B || kind == JUMP_KIND_C);

		assign word_in_tail[i] = word_count_t'(i) >= first_valid;
	end

	assign jump_found = |(word_is_jump & word_in_tail);

endmodule

`default_nettype wire

//--- verilog/fifo_level_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_level_tracker (
	input  logic                   main_clk,
	input  logic                   rst_n,
	input  fetch_pkg::fifo_level_t fifo_level_after_read,
	fetch_status_if.tracker        status,
	output fetch_pkg::fifo_level_t fifo_level,
	output fetch_pkg::fifo_level_t fifo_level_next
);

	import fetch_pkg::*;

	// ########################################
	// next level
	// ########################################

	// a jump flushes the queue, so whatever is left in it no longer counts.
	// a line that arrives during a jump is thrown away by the sequencer.
	always_comb begin
		if (status.jump_active) begin
			fifo_level_next = '0;
		end else if (status.line_ack && status.is_requesting) begin
			fifo_level_next = fifo_level_after_read + fifo_level_t'(status.returned_words);
		end else begin
			fifo_level_next = fifo_level_after_read;
		end
	end

	// ########################################
	// level register
	// ########################################

	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			fifo_level <= '0;
		end else begin
			fifo_level <= fifo_level_next;
		end
	end

	// the sequencer only asks for a line when it fits, so the queue never overfills.
	a_level_in_range: assert property (
		@(posedge main_clk) disable iff (!rst_n)
		fifo_level_next <= fifo_level_t'(FIFO_DEPTH)
	);

endmodule

`default_nettype wire

//--- verilog/fetch_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_sequencer (
	input  logic                   main_clk,
	input  logic                   rst_n,
	input  logic                   fetch_ack,
	input  fetch_pkg::fetch_line_t fetch_line,
	input  logic                   jump_strobe,
	input  logic [31:0]            jump_addr,
	input  fetch_pkg::fifo_level_t fifo_level_after_read,
	output logic                   fetch_req,
	output fetch_pkg::fetch_addr_t fetch_addr,
	fetch_status_if.seq            status
);

	import fetch_pkg::*;

	logic        req_q;
	fetch_addr_t addr_q;
	logic        jump_state_q;
	fetch_addr_t jump_addr_saved_q;
	logic        waiting_q;

	logic        jump_active;
	fetch_addr_t jump_target;
	word_count_t returned_words;
	logic [5:0]  level_with_line;
	logic        line_fits;
	logic        jump_found;

	// ########################################
	// combinational decode
	// ########################################

	assign jump_active = jump_strobe | jump_state_q;

	// a fresh strobe wins over a held one.
	// the target is forced to a halfword boundary.
	always_comb begin
		if (jump_strobe) begin
			jump_target = {jump_addr[25:1], 1'b0};
		end else begin
			jump_target = jump_addr_saved_q;
		end
	end

	assign returned_words = word_count_t'(LINE_WORDS) - {1'b0, addr_q[3:1]};

	assign level_with_line = {1'b0, fifo_level_after_read} + 6'(returned_words);
	assign line_fits = level_with_line < 6'(FIFO_DEPTH);

	jump_scanner u_jump_scanner (
		.line        (fetch_line),
		.valid_words (returned_words),
		.jump_found  (jump_found)
	);

	// ########################################
	// request and jump state
	// ########################################

	always_ff @(posedge main_clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q        <= 1'b0;
			addr_q       <= RESET_FETCH_ADDR;
			jump_state_q <= 1'b0;
			waiting_q    <= 1'b0;
		end else begin
			if (req_q) begin
				if (fetch_ack) begin
					if (jump_active) begin
						// the returned line belongs to the old path and is dropped.
						// the request stays up with the new address.
						jump_state_q <= 1'b0;
						waiting_q    <= 1'b0;
						addr_q       <= jump_target;
					end else begin
						addr_q <= addr_q + fetch_addr_t'({returned_words, 1'b0});
						req_q  <= 1'b0;
						if (jump_found) begin
							waiting_q <= 1'b1;
						end
					end
				end else if (jump_strobe) begin
					// memory is still busy, so the jump waits for its answer.
					jump_state_q <= 1'b1;
				end
			end else if (jump_active) begin
				jump_state_q <= 1'b0;
				waiting_q    <= 1'b0;
				addr_q       <= jump_target;
				req_q        <= 1'b1;
			end else if (!waiting_q && line_fits) begin
				req_q <= 1'b1;
			end
		end
	end

	// holds the target of a pending jump until the sequencer can take it.
	always_ff @(posedge main_clk) begin
		jump_addr_saved_q <= jump_target;
	end

	// ########################################
	// outputs
	// ########################################

	assign fetch_req  = req_q;
	assign fetch_addr = addr_q;

	assign status.is_requesting  = req_q;
	assign status.jump_active    = jump_active;
	assign status.line_ack       = fetch_ack;
	assign status.returned_words = returned_words;

	a_addr_aligned: assert property (
		@(posedge main_clk) disable iff (!rst_n)
		!fetch_addr[0]
	);

	// memory may answer late, the address must not move under it.
	a_addr_stable: assert property (
		@(posedge main_clk) disable iff (!rst_n)
		fetch_req && !fetch_ack |=> $stable(fetch_addr)
	);

endmodule

`default_nettype wire

//--- verilog/instruction_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_fetch_top (
	input  logic                   main_clk,
	input  logic                   rst_n,
	input  logic                   fetch_ack,
	input  fetch_pkg::fetch_line_t fetch_line,
	input  logic                   jump_strobe,
	input  logic [31:0]            jump_addr,
	input  fetch_pkg::fifo_level_t fifo_level_after_read,
	output logic                   fetch_req,
	output fetch_pkg::fetch_addr_t fetch_addr,
	output logic                   jump_active,
	output fetch_pkg::fifo_level_t fifo_level,
	output fetch_pkg::fifo_level_t fifo_level_next
);

	// status from the sequencer to the level tracker.
	fetch_status_if status_bus ();

	fetch_sequencer u_fetch_sequencer (
		.main_clk              (main_clk),
		.rst_n                 (rst_n),
		.fetch_ack             (fetch_ack),
		.fetch_line            (fetch_line),
		.jump_strobe           (jump_strobe),
		.jump_addr             (jump_addr),
		.fifo_level_after_read (fifo_level_after_read),
		.fetch_req             (fetch_req),
		.fetch_addr            (fetch_addr),
		.status                (status_bus.seq)
	);

	fifo_level_tracker u_fifo_level_tracker (
		.main_clk              (main_clk),
		.rst_n                 (rst_n),
		.fifo_level_after_read (fifo_level_after_read),
		.status                (status_bus.tracker),
		.fifo_level            (fifo_level),
		.fifo_level_next       (fifo_level_next)
	);

	assign jump_active = status_bus.jump_active;

endmodule

`default_nettype wire

//--- test/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

	import fetch_pkg::*;

	logic        main_clk;
	logic        rst_n;
	logic        fetch_ack;
	fetch_line_t fetch_line;
	logic        jump_strobe;
	logic [31:0] jump_addr;
	fifo_level_t fifo_level_after_read;
	logic        fetch_req;
	fetch_addr_t fetch_addr;
	logic        jump_active;
	fifo_level_t fifo_level;
	fifo_level_t fifo_level_next;

	integer seed;
	string  cur_test;
	int     checks;
	int     errors;
	int     tests_run;
	int     tests_failed;
	int     test_start;

	// expected state of the front end.
	logic        exp_req;
	fetch_addr_t exp_addr;
	logic        exp_jump_held;
	fetch_addr_t exp_saved;
	logic        exp_waiting;
	fifo_level_t exp_level;

	// memory responder state.
	logic in_flight;
	int   ack_delay;

	// events seen during the current test.
	int n_ack;
	int n_refill;
	int n_full;
	int n_stall;
	int n_outside;
	int n_idle_jump;
	int n_pending_jump;
	int n_discard;

	instruction_fetch_top uut (
		.main_clk              (main_clk),
		.rst_n                 (rst_n),
		.fetch_ack             (fetch_ack),
		.fetch_line            (fetch_line),
		.jump_strobe           (jump_strobe),
		.jump_addr             (jump_addr),
		.fifo_level_after_read (fifo_level_after_read),
		.fetch_req             (fetch_req),
		.fetch_addr            (fetch_addr),
		.jump_active           (jump_active),
		.fifo_level            (fifo_level),
		.fifo_level_next       (fifo_level_next)
	);

	always #10 main_clk = ~main_clk;

	// ########################################
	// helpers
	// ########################################

	function automatic int urand(input int n);
		int unsigned r;
		r = $unsigned($random(seed));
		return int'(r % n);
	endfunction

	function automatic logic is_jump_word(input instr_word_t w);
		return (w[15:11] == JUMP_PREFIX) &&
			(w[10:8] == JUMP_KIND_A || w[10:8] == JUMP_KIND_B || w[10:8] == JUMP_KIND_C);
	endfunction

	// only the last valid_words words of a line are delivered.
	function automatic logic line_has_jump(input fetch_line_t line, input word_count_t valid_words);
		logic found;
		found = 1'b0;
		for (int i = 0; i < LINE_WORDS; i++) begin
			if (i >= LINE_WORDS - int'(valid_words) && is_jump_word(line[i])) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	function automatic fetch_line_t random_line(input int jword_pct);
		fetch_line_t line;
		logic [2:0]  kind;
		for (int i = 0; i < LINE_WORDS; i++) begin
			line[i] = instr_word_t'($random(seed));
			// a random word that happens to be a jump word loses bit 11.
			// words with the prefix and another kind stay as they are.
			if (is_jump_word(line[i])) begin
				line[i][11] = 1'b0;
			end
		end
		if (urand(100) < jword_pct) begin
			case (urand(3))
				0: kind = JUMP_KIND_A;
				1: kind = JUMP_KIND_B;
				default: kind = JUMP_KIND_C;
			endcase
			line[urand(LINE_WORDS)] = {JUMP_PREFIX, kind, 8'(urand(256))};
		end
		return line;
	endfunction

	task automatic check_addr(input string what, input fetch_addr_t expected,
		input fetch_addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH test %s, %s expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_level(input string what, input fifo_level_t expected,
		input fifo_level_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH test %s, %s expected %0d actual %0d", cur_test, what, expected,
				actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH test %s, %s expected %b actual %b", cur_test, what, expected, actual);
		end
	endtask

	task automatic require_seen(input int count, input string what);
		if (count == 0) begin
			errors++;
			$display("test %s: %s never happened", cur_test, what);
		end
	endtask

	task automatic clear_counts();
		n_ack = 0;
		n_refill = 0;
		n_full = 0;
		n_stall = 0;
		n_outside = 0;
		n_idle_jump = 0;
		n_pending_jump = 0;
		n_discard = 0;
	endtask

	task automatic finish_test(input int errors_at_start);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
		end
	endtask

	// ########################################
	// one clock cycle, starting at a falling edge
	// ########################################

	task automatic step(input int jump_pct, input int jword_pct, input int drain_max);
		fetch_line_t line;
		logic        ack;
		logic        strobe;
		logic [31:0] jaddr;
		fifo_level_t after_rd;
		fifo_level_t exp_next;
		word_count_t rw;
		fetch_addr_t target;
		logic        jump_now;
		int          drain;

		check_flag("fetch_req", exp_req, fetch_req);
		check_addr("fetch_addr", exp_addr, fetch_addr);
		check_level("fifo_level", exp_level, fifo_level);

		// a request is answered 1 to 6 cycles after it is first seen.
		ack = 1'b0;
		if (in_flight) begin
			ack_delay--;
			if (ack_delay == 0) begin
				ack = 1'b1;
				in_flight = 1'b0;
			end
		end else if (fetch_req) begin
			in_flight = 1'b1;
			ack_delay = 1 + urand(6);
		end
		line = random_line(jword_pct);

		drain = urand(drain_max + 1);
		after_rd = (int'(exp_level) > drain) ? fifo_level_t'(int'(exp_level) - drain) : '0;
		strobe = urand(100) < jump_pct;
		jaddr = $random(seed);
		jaddr[0] = 1'b0;

		fetch_ack = ack;
		fetch_line = line;
		jump_strobe = strobe;
		jump_addr = jaddr;
		fifo_level_after_read = after_rd;
		#1;

		rw = word_count_t'(LINE_WORDS) - word_count_t'(exp_addr[3:1]);
		jump_now = strobe | exp_jump_held;
		target = strobe ? {jaddr[25:1], 1'b0} : exp_saved;
		if (jump_now) begin
			exp_next = '0;
		end else if (ack && exp_req) begin
			exp_next = after_rd + fifo_level_t'(rw);
		end else begin
			exp_next = after_rd;
		end
		check_flag("jump_active", jump_now, jump_active);
		check_level("fifo_level_next", exp_next, fifo_level_next);

		// state after the next rising edge.
		if (exp_req) begin
			if (ack && jump_now) begin
				exp_jump_held = 1'b0;
				exp_waiting = 1'b0;
				exp_addr = target;
				n_discard++;
			end else if (ack) begin
				exp_addr = exp_addr + (fetch_addr_t'(rw) << 1);
				exp_req = 1'b0;
				n_ack++;
				if (line_has_jump(line, rw)) begin
					exp_waiting = 1'b1;
				end else if (line_has_jump(line, word_count_t'(LINE_WORDS))) begin
					n_outside++;
				end
			end else if (strobe) begin
				exp_jump_held = 1'b1;
				n_pending_jump++;
			end
		end else if (jump_now) begin
			exp_jump_held = 1'b0;
			exp_waiting = 1'b0;
			exp_addr = target;
			exp_req = 1'b1;
			n_idle_jump++;
		end else if (exp_waiting) begin
			n_stall++;
		end else if (int'(after_rd) + int'(rw) < FIFO_DEPTH) begin
			exp_req = 1'b1;
			n_refill++;
		end else begin
			n_full++;
		end
		exp_saved = target;
		exp_level = exp_next;

		@(negedge main_clk);
	endtask

	task automatic wait_for_request(input int limit);
		int n;
		n = 0;
		while (!fetch_req && n < limit) begin
			step(0, 0, 3);
			n++;
		end
		if (!fetch_req) begin
			errors++;
			$display("test %s: fetch_req did not rise within %0d cycles", cur_test, limit);
		end
	endtask

	task automatic run_random(input int cycles, input int jump_pct, input int jword_pct,
		input int drain_max);
		clear_counts();
		for (int n = 0; n < cycles; n++) begin
			step(jump_pct, jword_pct, drain_max);
		end
	endtask

	// ########################################
	// test sequence
	// ########################################

	initial begin
		seed = 32'h03d2_b39c;
		main_clk = 1'b0;
		rst_n = 1'b0;
		fetch_ack = 1'b0;
		fetch_line = '0;
		jump_strobe = 1'b0;
		jump_addr = '0;
		fifo_level_after_read = '0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		exp_req = 1'b0;
		exp_addr = RESET_FETCH_ADDR;
		exp_jump_held = 1'b0;
		exp_saved = '0;
		exp_waiting = 1'b0;
		exp_level = '0;
		in_flight = 1'b0;
		ack_delay = 0;

		repeat (16) @(posedge main_clk);
		@(negedge main_clk);
		rst_n = 1'b1;

		cur_test = "reset";
		test_start = errors;
		check_flag("fetch_req", 1'b0, fetch_req);
		check_flag("jump_active", 1'b0, jump_active);
		check_level("fifo_level", '0, fifo_level);
		check_addr("fetch_addr", RESET_FETCH_ADDR, fetch_addr);
		wait_for_request(20);
		check_addr("first request address", RESET_FETCH_ADDR, fetch_addr);
		finish_test(test_start);

		// slow draining fills the queue, so refills are also held back.
		cur_test = "sequential_fetch";
		test_start = errors;
		run_random(600, 0, 0, 1);
		require_seen(n_ack, "an acknowledge without a jump");
		require_seen(n_refill, "a refill request");
		require_seen(n_full, "a refill held back by a full queue");
		finish_test(test_start);

		cur_test = "jump_word_stall";
		test_start = errors;
		run_random(3000, 4, 25, 3);
		require_seen(n_stall, "a stall after a jump word");
		require_seen(n_outside, "a jump word outside the valid tail");
		finish_test(test_start);

		cur_test = "random_jumps";
		test_start = errors;
		run_random(3000, 10, 25, 3);
		require_seen(n_idle_jump, "a jump while idle");
		require_seen(n_pending_jump, "a jump held during a fetch");
		require_seen(n_discard, "a discarded line");
		finish_test(test_start);

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- instruction_fetch.f
verilog/fetch_pkg.sv
verilog/fetch_status_if.sv
verilog/jump_scanner.sv
verilog/fifo_level_tracker.sv
verilog/fetch_sequencer.sv
verilog/instruction_fetch_top.sv
test/fetch_tb.sv

//--- Makefile
# Verilator build and run of the instruction fetch testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= instruction_fetch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTS PASSED

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv) $(wildcard test/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help    list these targets"
	@echo "  test    build with Verilator and run the testbench"
	@echo "  clean   remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
